// ==== sim.f ====
hdl/codecPkg.sv
hdl/modelPkg.sv
hdl/freqModel.sv
hdl/seqDivider.sv
hdl/encoderCtrl.sv
hdl/bitPacker.sv
hdl/arithEncoder.sv
tests/clockGen.sv
tests/tbArithEncoder.sv

// ==== Bender.yml ====
package:
  name: arith_encoder

sources:
  - hdl/codecPkg.sv
  - hdl/modelPkg.sv
  - hdl/freqModel.sv
  - hdl/seqDivider.sv
  - hdl/encoderCtrl.sv
  - hdl/bitPacker.sv
  - hdl/arithEncoder.sv
  - target: simulation
    files:
      - tests/clockGen.sv
      - tests/tbArithEncoder.sv

// ==== tests/tbArithEncoder.sv ====
// table-driven test against a 64-bit model of the coding rules; streams stay under 128 symbols
`timescale 1ns/1ns

module tbArithEncoder
    import codecPkg::*;
    import modelPkg::*;
();

    localparam int Precision  = PrecisionDefault;
    localparam int DriveDelay = 5;    // ns after the rising edge
    localparam int Timeout    = 3000; // cycles allowed per wait
    localparam int MaxSymbols = 128;
    localparam int MaxWords   = 64;
    localparam int NumRows    = 4;
    localparam int NumFixed   = 16;

    // low and high symbols mixed, first symbol in the low byte
    localparam logic [NumFixed*8-1:0] FixedList = {
        8'd99, 8'd97, 8'd20, 8'd254, 8'd64, 8'd180, 8'd3, 8'd97,
        8'd130, 8'd50, 8'd200, 8'd1, 8'd255, 8'd98, 8'd96, 8'd0
    };

    typedef struct packed {
        logic       useFixed;  // start with the fixed list
        logic       reuse;     // replay the symbols of the row before
        logic [7:0] hotRun;    // leading HotSymbol count
        logic [7:0] randCount; // random symbols after the hot run
        logic [3:0] maxDelay;  // handshake delay bound in cycles
        logic [3:0] minFull;   // full words the row must give at least
    } stimRowT;

    logic       clk;
    logic       rstn;
    logic       start;
    symbolT     symbolIn;
    logic       symbolProvided;
    logic       symbolRequest;
    logic       idle;
    logic       wordReady;
    logic       wordRead;
    wordT       word;
    logic [2:0] validBytes;

    stimRowT    stimTable [0:NumRows-1];
    integer     seed;
    int         symbols [0:MaxSymbols-1];
    int         numSymbols;
    wordT       expWord [0:MaxWords-1];
    logic [2:0] expBytes [0:MaxWords-1];
    int         expCount;
    int         gotCount;
    wordT       curWord;
    int         bitCount;
    int         leftCount;
    int         rightCount;
    int         middleCount;
    int         flushCount; // left or right steps that released pending bits

    clockGen #(
        .HalfPeriod  (20),
        .ResetCycles (4)
    ) i_clockGen (
        .clk  (clk),
        .rstn (rstn)
    );

    arithEncoder #(
        .Precision (Precision)
    ) i_dut (
        .clk            (clk),
        .rstn           (rstn),
        .start          (start),
        .symbolIn       (symbolIn),
        .symbolProvided (symbolProvided),
        .symbolRequest  (symbolRequest),
        .idle           (idle),
        .wordReady      (wordReady),
        .wordRead       (wordRead),
        .word           (word),
        .validBytes     (validBytes)
    );

    task automatic checkEq(input string name, input logic [63:0] got, input logic [63:0] expected);
        if (got !== expected) begin
            $display("Fail %s: got 0x%0h expected 0x%0h", name, got, expected);
            $display("CHECKS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic failNow(input string what);
        $display("%s", what);
        $display("CHECKS FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic tick;
        @(posedge clk);
        #DriveDelay;
    endtask

    task automatic pause(input int maxDelay);
        int n;
        n = (maxDelay == 0) ? 0 : $unsigned($random(seed)) % (maxDelay + 1);
        repeat (n) tick();
    endtask

    // cumulative bounds straight from the four model regions
    task automatic boundsOf(input int sym, output longint lo, output longint hi);
        if (sym < HotSymbol) begin
            lo = sym;
            hi = sym + 1;
        end else if (sym == HotSymbol) begin
            lo = HotSymbol;
            hi = HotEnd;
        end else if (sym < EofSymbol) begin
            lo = sym + HighOffset;
            hi = sym + HighOffset + 1;
        end else begin
            lo = EofBegin;
            hi = TotalFreq;
        end
    endtask

    task automatic pushBit(input bit value, input bit last);
        curWord[bitCount] = value;
        bitCount++;
        if ((bitCount == 32) || last) begin
            expWord[expCount]  = curWord;
            expBytes[expCount] = last ? (bitCount + 7) / 8 : 4;
            expCount++;
            curWord  = '0;
            bitCount = 0;
        end
    endtask

    task automatic buildReference;
        longint a;
        longint b;
        longint w;
        longint lo;
        longint hi;
        longint half;
        longint quarter;
        int     pend;
        bit     stop;
        bit     lastBit;
        half     = 64'd1 << (Precision - 2);
        quarter  = half / 2;
        a        = 0;
        b        = 2 * half;
        w        = b;
        pend     = 0;
        expCount = 0;
        curWord  = '0;
        bitCount = 0;
        for (int i = 0; i < numSymbols; i++) begin
            boundsOf(symbols[i], lo, hi);
            b    = a + w * hi / TotalFreq; // both bounds from the old a
            a    = a + w * lo / TotalFreq;
            stop = 1'b0;
            while (!stop) begin
                if ((b < half) || (a > half)) begin
                    lastBit = (b >= half);
                    if (lastBit) begin
                        a = a - half;
                        b = b - half;
                        rightCount++;
                    end else begin
                        leftCount++;
                    end
                    a = 2 * a;
                    b = 2 * b;
                    pushBit(lastBit, 1'b0);
                    if (pend > 0) begin
                        flushCount++;
                    end
                    repeat (pend) pushBit(!lastBit, 1'b0);
                    pend = 0;
                end else if ((a > quarter) && (b < 3 * quarter)) begin
                    a = 2 * (a - quarter);
                    b = 2 * (b - quarter);
                    pend++;
                    middleCount++;
                end else begin
                    stop = 1'b1;
                end
            end
            w = b - a;
        end
        pend++;
        lastBit = (a > quarter);
        pushBit(lastBit, 1'b0);
        for (int k = 1; k <= pend; k++) begin
            pushBit(!lastBit, k == pend);
        end
    endtask

    task automatic waitResetDone;
        int cycles;
        cycles = 0;
        while (rstn !== 1'b1) begin
            if (cycles == Timeout) begin
                failNow("reset never released");
            end else begin
                tick();
                cycles++;
            end
        end
    endtask

    task automatic waitEvent;
        int cycles;
        cycles = 0;
        while (!(wordReady || symbolRequest || idle)) begin
            if (cycles == Timeout) begin
                failNow("timeout: encoder gave no wordReady, symbolRequest or idle");
            end else begin
                tick();
                cycles++;
            end
        end
    endtask

    task automatic waitWordReadyLow;
        int cycles;
        cycles = 0;
        while (wordReady) begin
            if (cycles == Timeout) begin
                failNow("timeout: wordReady never dropped after wordRead");
            end else begin
                tick();
                cycles++;
            end
        end
    endtask

    task automatic waitSymbolRequestLow;
        int cycles;
        cycles = 0;
        while (symbolRequest) begin
            if (cycles == Timeout) begin
                failNow("timeout: symbolRequest never dropped after symbolProvided");
            end else begin
                tick();
                cycles++;
            end
        end
    endtask

    task automatic runStream(input int maxDelay);
        int symIdx;
        bit done;
        symIdx   = 1;
        gotCount = 0;
        done     = 1'b0;
        symbolIn = symbolT'(symbols[0]);
        start    = 1'b1;
        tick();
        start = 1'b0;
        while (!done) begin
            waitEvent();
            if (wordReady) begin
                if (gotCount >= expCount) begin
                    failNow("encoder released more words than the reference predicts");
                end else begin
                    checkEq($sformatf("word[%0d]", gotCount), word, expWord[gotCount]);
                    checkEq($sformatf("validBytes[%0d]", gotCount), validBytes,
                            expBytes[gotCount]);
                    gotCount++;
                    pause(maxDelay);
                    wordRead = 1'b1;
                    waitWordReadyLow();
                    wordRead = 1'b0;
                end
            end else if (symbolRequest) begin
                if (symIdx >= numSymbols) begin
                    failNow("encoder requested a symbol after end-of-stream");
                end else begin
                    pause(maxDelay);
                    symbolIn = symbolT'(symbols[symIdx]);
                    symIdx++;
                    symbolProvided = 1'b1;
                    waitSymbolRequestLow();
                    symbolProvided = 1'b0;
                end
            end else begin
                done = 1'b1; // back in idle
            end
        end
        checkEq("symbols consumed", symIdx, numSymbols);
        checkEq("word count", gotCount, expCount);
    endtask

    initial begin : mainSeq
        start          = 1'b0;
        symbolIn       = '0;
        symbolProvided = 1'b0;
        wordRead       = 1'b0;
        seed           = 32'h178;
        leftCount      = 0;
        rightCount     = 0;
        middleCount    = 0;
        flushCount     = 0;
        // useFixed, reuse, hotRun, randCount, maxDelay, minFull
        stimTable[0] = {1'b0, 1'b0, 8'd0, 8'd0, 4'd0, 4'd0};   // EOF alone
        stimTable[1] = {1'b1, 1'b0, 8'd0, 8'd0, 4'd0, 4'd2};   // low and high symbols
        stimTable[2] = {1'b0, 1'b0, 8'd60, 8'd24, 4'd0, 4'd2}; // hot run then random
        stimTable[3] = {1'b0, 1'b1, 8'd0, 8'd0, 4'd7, 4'd2};   // same stream, delayed
        waitResetDone();
        tick();
        checkEq("idle", idle, 1'b1);
        checkEq("wordReady", wordReady, 1'b0);
        checkEq("symbolRequest", symbolRequest, 1'b0);
        for (int row = 0; row < NumRows; row++) begin
            if (!stimTable[row].reuse) begin
                numSymbols = 0;
                if (stimTable[row].useFixed) begin
                    for (int i = 0; i < NumFixed; i++) begin
                        symbols[numSymbols] = FixedList[i*8 +: 8];
                        numSymbols++;
                    end
                end
                for (int i = 0; i < stimTable[row].hotRun; i++) begin
                    symbols[numSymbols] = HotSymbol;
                    numSymbols++;
                end
                for (int i = 0; i < stimTable[row].randCount; i++) begin
                    symbols[numSymbols] = $unsigned($random(seed)) % 256;
                    numSymbols++;
                end
                symbols[numSymbols] = EofSymbol;
                numSymbols++;
            end
            buildReference();
            runStream(stimTable[row].maxDelay);
            checkEq("enough full words", (gotCount - 1) >= stimTable[row].minFull, 1'b1);
        end
        // the streams must have gone through every rescale case
        checkEq("left rescales seen", leftCount > 0, 1'b1);
        checkEq("right rescales seen", rightCount > 0, 1'b1);
        checkEq("middle rescales seen", middleCount > 0, 1'b1);
        checkEq("pending bits flushed", flushCount > 0, 1'b1);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// ==== tests/clockGen.sv ====
// testbench clock and active-low reset; reset releases 1 ns after its last rising edge
`timescale 1ns/1ns

module clockGen #(
    parameter int HalfPeriod  = 20,
    parameter int ResetCycles = 4
) (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #HalfPeriod clk = ~clk;
    end

    initial begin
        rstn = 1'b0;
        repeat (ResetCycles) @(posedge clk);
        #1 rstn = 1'b1; // clear of the sampling point
    end

endmodule

// ==== hdl/arithEncoder.sv ====
// arithmetic encoder top; symbol and word handshakes are level based and must be cleared by the user
`timescale 1ns/1ns

module arithEncoder
    import codecPkg::*;
    import modelPkg::*;
#(
    parameter int Precision = PrecisionDefault
) (
    input  logic       clk,
    input  logic       rstn,
    input  logic       start,
    input  symbolT     symbolIn,
    input  logic       symbolProvided,
    output logic       symbolRequest,
    output logic       idle,
    output logic       wordReady,
    input  logic       wordRead,
    output wordT       word,
    output logic [2:0] validBytes
);

    symbolT                        modelSymbol;
    freqBoundsT                    freqBounds;
    logic                          divStart;
    logic [Precision+FreqBits-1:0] dividend;
    logic                          divDone;
    logic [Precision-1:0]          quotient;
    outBitT                        outBit;
    logic                          wordBusy;

    freqModel i_freqModel (
        .modelSymbol (modelSymbol),
        .freqBounds  (freqBounds)
    );

    seqDivider #(
        .Precision (Precision),
        .FreqBits  (FreqBits)
    ) i_seqDivider (
        .clk      (clk),
        .rstn     (rstn),
        .divStart (divStart),
        .dividend (dividend),
        .divDone  (divDone),
        .quotient (quotient)
    );

    encoderCtrl #(
        .Precision (Precision)
    ) i_encoderCtrl (
        .clk            (clk),
        .rstn           (rstn),
        .start          (start),
        .symbolIn       (symbolIn),
        .symbolProvided (symbolProvided),
        .symbolRequest  (symbolRequest),
        .idle           (idle),
        .modelSymbol    (modelSymbol),
        .freqBounds     (freqBounds),
        .divStart       (divStart),
        .dividend       (dividend),
        .divDone        (divDone),
        .quotient       (quotient),
        .outBit         (outBit),
        .wordBusy       (wordBusy)
    );

    bitPacker i_bitPacker (
        .clk        (clk),
        .rstn       (rstn),
        .outBit     (outBit),
        .wordBusy   (wordBusy),
        .wordReady  (wordReady),
        .wordRead   (wordRead),
        .word       (word),
        .validBytes (validBytes)
    );

endmodule

// ==== hdl/bitPacker.sv ====
// LSB-first word packer; a word holds until the reader raises and then clears wordRead
`timescale 1ns/1ns

module bitPacker
    import codecPkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  outBitT     outBit,
    output logic       wordBusy,
    output logic       wordReady,
    input  logic       wordRead,
    output wordT       word,
    output logic [2:0] validBytes
);

    bitPosT bitPos; // next free bit in the word
    logic   accept;

    assign accept = outBit.valid && !wordBusy;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            bitPos    <= '0;
            word      <= '0;  // unused bits must read as zero
            wordReady <= 1'b0;
            wordBusy  <= 1'b0;
        end else begin
            if (accept) begin
                word[bitPos] <= outBit.value;
                bitPos       <= bitPos + 1'b1;
                if ((bitPos == '1) || outBit.last) begin
                    wordBusy   <= 1'b1;
                    wordReady  <= 1'b1;
                    // ceil of filled bits over 8 for the final word
                    validBytes <= outBit.last ? {1'b0, bitPos[4:3]} + 3'd1 : 3'd4;
                end
            end else if (wordReady && wordRead) begin
                wordReady <= 1'b0;
                word      <= '0;
                bitPos    <= '0;
            end else if (wordBusy && !wordReady && !wordRead) begin
                wordBusy <= 1'b0; // reader has dropped its flag
            end
        end
    end

endmodule

// ==== hdl/encoderCtrl.sv ====
// encoder FSM; at most one symbol in flight and no more than 127 consecutive middle rescales
`timescale 1ns/1ns

module encoderCtrl
    import codecPkg::*;
    import modelPkg::*;
#(
    parameter int Precision = PrecisionDefault
) (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          start,
    input  symbolT                        symbolIn,
    input  logic                          symbolProvided,
    output logic                          symbolRequest,
    output logic                          idle,
    output symbolT                        modelSymbol,
    input  freqBoundsT                    freqBounds,
    output logic                          divStart,
    output logic [Precision+FreqBits-1:0] dividend,
    input  logic                          divDone,
    input  logic [Precision-1:0]          quotient,
    output outBitT                        outBit,
    input  logic                          wordBusy
);

    typedef logic [Precision-1:0] intervalT;
    typedef logic [Precision+FreqBits-1:0] productT;

    localparam intervalT Whole         = intervalT'(1) << (Precision - 1);
    localparam intervalT Half          = intervalT'(1) << (Precision - 2);
    localparam intervalT Quarter       = intervalT'(1) << (Precision - 3);
    localparam intervalT ThreeQuarters = Half + Quarter;

    encStateT state;
    encStateT resumeState; // where to go once the packer frees up
    symbolT   symbol;
    intervalT a;
    intervalT b;
    intervalT w;
    pendingT  pending;
    logic     pendBit;     // value of the pending bits still owed
    logic     closing;     // termination bits are being sent
    freqT     mulFreq;
    productT  product;

    assign idle        = (state == Idle);
    assign modelSymbol = symbol;

    // single multiplier, end bound first and begin bound second
    assign mulFreq = (state == Multiply) ? freqBounds.freqEnd : freqBounds.freqBegin;
    assign product = productT'(w) * productT'(mulFreq);

    always_comb begin
        outBit = '0;
        case (state)
            Rescale: begin
                outBit.valid = !wordBusy && ((b < Half) || (a > Half));
                outBit.value = (b >= Half); // right half emits 1
            end
            EmitPending: begin
                outBit.valid = !wordBusy;
                outBit.value = pendBit;
                outBit.last  = closing && (pending == 1);
            end
            Terminate: begin
                outBit.valid = !wordBusy;
                outBit.value = (a > Quarter);
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state         <= Idle;
            symbolRequest <= 1'b0;
            divStart      <= 1'b0;
        end else begin
            divStart <= 1'b0;
            case (state)
                Idle: if (start) begin
                    symbol  <= symbolIn;
                    a       <= '0;
                    b       <= Whole;
                    w       <= Whole;
                    pending <= '0;
                    closing <= 1'b0;
                    state   <= Multiply;
                end
                Multiply: begin
                    dividend <= product; // w * end
                    divStart <= 1'b1;
                    state    <= DivideEnd;
                end
                DivideEnd: if (divDone) begin
                    b        <= a + quotient;
                    dividend <= product; // w * begin
                    divStart <= 1'b1;
                    state    <= DivideBegin;
                end
                DivideBegin: if (divDone) begin
                    a     <= a + quotient;
                    state <= Rescale;
                end
                Rescale: begin
                    if (wordBusy) begin
                        resumeState <= Rescale;
                        state       <= WaitPack;
                    end else if (b < Half) begin
                        a       <= a << 1;
                        b       <= b << 1;
                        pendBit <= 1'b1;
                        state   <= (pending != '0) ? EmitPending : Rescale;
                    end else if (a > Half) begin
                        a       <= (a - Half) << 1;
                        b       <= (b - Half) << 1;
                        pendBit <= 1'b0;
                        state   <= (pending != '0) ? EmitPending : Rescale;
                    end else if ((a > Quarter) && (b < ThreeQuarters)) begin
                        a       <= (a - Quarter) << 1; // middle case, bit deferred
                        b       <= (b - Quarter) << 1;
                        pending <= pending + 1'b1;
                    end else begin
                        w <= b - a;
                        if (symbol == EofSymbol) begin
                            state <= Terminate;
                        end else begin
                            symbolRequest <= 1'b1;
                            state         <= WaitSymbol;
                        end
                    end
                end
                EmitPending: begin
                    if (wordBusy) begin
                        resumeState <= EmitPending;
                        state       <= WaitPack;
                    end else begin
                        pending <= pending - 1'b1;
                        if (pending == 1) begin
                            resumeState <= Idle; // only used after the final bit
                            state       <= closing ? WaitPack : Rescale;
                        end
                    end
                end
                Terminate: begin
                    if (wordBusy) begin
                        resumeState <= Terminate;
                        state       <= WaitPack;
                    end else begin
                        pending <= pending + 1'b1;
                        pendBit <= (a <= Quarter);
                        closing <= 1'b1;
                        state   <= EmitPending;
                    end
                end
                WaitSymbol: begin
                    if (symbolRequest && symbolProvided) begin
                        symbol        <= symbolIn;
                        symbolRequest <= 1'b0;
                    end else if (!symbolRequest && !symbolProvided) begin
                        state <= Multiply; // provider has cleared its flag
                    end
                end
                WaitPack: if (!wordBusy) begin
                    state <= resumeState;
                end
                default: state <= Idle;
            endcase
        end
    end

endmodule

// ==== hdl/seqDivider.sv ====
// restoring divide by TotalFreq; quotient must fit Precision bits and is valid with divDone
`timescale 1ns/1ns

module seqDivider
    import modelPkg::*;
#(
    parameter int Precision = 24,
    parameter int FreqBits  = modelPkg::FreqBits
) (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          divStart,
    input  logic [Precision+FreqBits-1:0] dividend,
    output logic                          divDone,
    output logic [Precision-1:0]          quotient
);

    localparam int Steps = Precision + FreqBits; // one quotient bit per step

    logic [Steps-1:0]           dividendReg;
    logic [FreqBits-1:0]        remainder;
    logic [$clog2(Steps+1)-1:0] count;
    logic [FreqBits:0]          trial;
    logic [FreqBits:0]          diff;
    logic                       fits;

    // next partial remainder with the dividend MSB shifted in
    assign trial = {remainder, dividendReg[Steps-1]};
    assign diff  = trial - (FreqBits+1)'(TotalFreq);
    assign fits  = trial >= (FreqBits+1)'(TotalFreq);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            count   <= '0;
            divDone <= 1'b0;
        end else begin
            divDone <= 1'b0;
            if (divStart) begin
                dividendReg <= dividend;
                remainder   <= '0;
                count       <= $bits(count)'(Steps);
            end else if (count != '0) begin
                dividendReg <= dividendReg << 1;
                remainder   <= fits ? diff[FreqBits-1:0] : trial[FreqBits-1:0];
                quotient    <= {quotient[Precision-2:0], fits}; // upper bits are zero by range
                count       <= count - 1'b1;
                if (count == 1) begin
                    divDone <= 1'b1; // last quotient bit lands with this edge
                end
            end
        end
    end

endmodule

// ==== hdl/freqModel.sv ====
// combinational model lookup; any symbol code above 256 is treated as end-of-stream
`timescale 1ns/1ns

module freqModel
    import modelPkg::*;
(
    input  symbolT     modelSymbol,
    output freqBoundsT freqBounds
);

    freqT symbolFreq;

    assign symbolFreq = freqT'(modelSymbol);

    always_comb begin
        if (modelSymbol < HotSymbol) begin
            freqBounds.freqBegin = symbolFreq; // unit-width low symbols
            freqBounds.freqEnd   = symbolFreq + 1'b1;
        end else if (modelSymbol == HotSymbol) begin
            freqBounds.freqBegin = symbolFreq;
            freqBounds.freqEnd   = HotEnd; // takes nearly the whole range
        end else if (modelSymbol < EofSymbol) begin
            freqBounds.freqBegin = symbolFreq + HighOffset;
            freqBounds.freqEnd   = symbolFreq + HighOffset + 1'b1;
        end else begin
            freqBounds.freqBegin = EofBegin;
            freqBounds.freqEnd   = TotalFreq;
        end
    end

endmodule

// ==== hdl/modelPkg.sv ====
// fixed 257-symbol frequency model; symbol 256 is end-of-stream and the total is 2^21 - 1
package modelPkg;

    localparam int NumSymbols = 257;
    localparam int EofSymbol  = 256;
    localparam int HotSymbol  = 97;  // the one wide symbol
    localparam int FreqBits   = 21;

    typedef logic [$clog2(NumSymbols)-1:0] symbolT;
    typedef logic [FreqBits-1:0] freqT; // cumulative frequency

    localparam freqT HotEnd     = 21'd2096972;
    localparam freqT HighOffset = 21'd2096874; // symbols above the hot one sit here
    localparam freqT EofBegin   = 21'd2097130;
    localparam freqT TotalFreq  = 21'd2097151;

    // cumulative bounds of one symbol
    typedef struct packed {
        freqT freqBegin;
        freqT freqEnd;
    } freqBoundsT;

endpackage

// ==== hdl/codecPkg.sv ====
// encoder types that do not depend on Precision; pending count limited to 127 middle-case bits
package codecPkg;

    localparam int PrecisionDefault = 24; // interval precision in bits

    typedef logic [6:0]  pendingT; // outstanding middle-case bits
    typedef logic [4:0]  bitPosT;  // bit index inside an output word
    typedef logic [31:0] wordT;

    // one coded bit handed from the controller to the packer
    typedef struct packed {
        logic valid;
        logic value;
        logic last; // final bit of the stream
    } outBitT;

    typedef enum logic [3:0] {
        Idle,
        Multiply,
        DivideEnd,
        DivideBegin,
        Rescale,
        EmitPending,
        Terminate,
        WaitSymbol,
        WaitPack
    } encStateT;

endpackage
